// File: eth_rx_pkg.sv
package eth_rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Beat and frame descriptors
    ////////////////////////////////////////////////////////////////////////////

    // One GMII receive beat as sampled from the PHY
    typedef struct packed {
        logic [7:0] rxd;
        logic       rx_dv;
        logic       rx_er;
    } gmii_rx_t;

    // One byte of the receive stream, valid travels alongside
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       bad;
    } rx_beat_t;

    // Recognized LFC control frame fields
    typedef struct packed {
        logic [15:0] opcode;
        logic [15:0] quanta;
    } mcf_info_t;

    // Control frame recognition and pause enables
    typedef struct packed {
        logic [15:0] eth_type;
        logic [15:0] lfc_opcode;
        logic        forward;
        logic        lfc_en;
    } mcf_cfg_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_DROP
    } framer_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0]  ETH_PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  ETH_SFD_BYTE      = 8'hD5;
    localparam logic [31:0] CRC32_POLY        = 32'hEDB88320;
    // Register value after a good frame and its FCS, no final inversion
    localparam logic [31:0] CRC32_RESIDUE     = 32'hDEBB20E3;
    localparam int          FCS_BYTES         = 4;
    // Header bytes up to and including the quanta field
    localparam int          MCF_HDR_BYTES     = 18;
    localparam int          QUANTA_WIDTH      = 16;

    // Reflected CRC-32 advanced by one byte, LSB first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: gmii_rx_framer.sv
`timescale 1ns/1ps

module gmii_rx_framer
    import eth_rx_pkg::*;
(
    input  logic     rx_clk,
    input  logic     rx_rst,
    input  gmii_rx_t gmii,
    output logic     out_valid,
    output rx_beat_t out_beat,
    output logic     start_packet,
    output logic     error_bad_frame
);

    framer_state_t state;

    // One byte is held back so that last can be set when rx_dv falls
    logic [7:0] hold_data;
    logic       hold_vld;
    logic       frame_err;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state           <= ST_IDLE;
            hold_vld        <= 1'b0;
            frame_err       <= 1'b0;
            out_valid       <= 1'b0;
            start_packet    <= 1'b0;
            error_bad_frame <= 1'b0;
        end else begin
            out_valid       <= 1'b0;
            start_packet    <= 1'b0;
            error_bad_frame <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (gmii.rx_dv) begin
                        if (gmii.rxd == ETH_PREAMBLE_BYTE && !gmii.rx_er) begin
                            state <= ST_PREAMBLE;
                        end else begin
                            state <= ST_DROP;
                        end
                    end
                end
                ST_PREAMBLE: begin
                    if (!gmii.rx_dv) begin
                        state <= ST_IDLE;
                    end else if (gmii.rx_er) begin
                        state <= ST_DROP;
                    end else if (gmii.rxd == ETH_SFD_BYTE) begin
                        state        <= ST_PAYLOAD;
                        start_packet <= 1'b1;
                        hold_vld     <= 1'b0;
                        frame_err    <= 1'b0;
                    end else if (gmii.rxd != ETH_PREAMBLE_BYTE) begin
                        state <= ST_DROP;
                    end
                end
                ST_PAYLOAD: begin
                    out_valid <= hold_vld;
                    if (gmii.rx_dv) begin
                        hold_vld <= 1'b1;
                        if (gmii.rx_er) begin
                            frame_err <= 1'b1;
                        end
                    end else begin
                        // End of frame, held byte leaves as last
                        error_bad_frame <= hold_vld && frame_err;
                        hold_vld        <= 1'b0;
                        state           <= ST_IDLE;
                    end
                end
                ST_DROP: begin
                    if (!gmii.rx_dv) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge rx_clk) begin
        if (state == ST_PAYLOAD) begin
            out_beat.data <= hold_data;
            out_beat.last <= !gmii.rx_dv;
            out_beat.bad  <= !gmii.rx_dv && frame_err;
            if (gmii.rx_dv) begin
                hold_data <= gmii.rxd;
            end
        end
    end

endmodule

// File: eth_fcs_check.sv
`timescale 1ns/1ps

module eth_fcs_check
    import eth_rx_pkg::*;
(
    input  logic     rx_clk,
    input  logic     rx_rst,
    input  logic     in_valid,
    input  rx_beat_t in_beat,
    output logic     out_valid,
    output rx_beat_t out_beat,
    output logic     error_bad_fcs
);

    localparam int CNT_W  = $clog2(FCS_BYTES + 1);
    localparam int HOLD_W = FCS_BYTES * 8;

    logic [31:0]       crc_q;
    logic [31:0]       crc_next;
    logic [HOLD_W-1:0] hold_q;
    logic [CNT_W-1:0]  hold_cnt;
    logic              hold_full;
    logic              crc_bad;

    ////////////////////////////////////////////////////////////////////////////
    // CRC over every byte of the frame, FCS included
    ////////////////////////////////////////////////////////////////////////////

    assign crc_next  = crc32_byte(crc_q, in_beat.data);
    assign crc_bad   = crc_next != CRC32_RESIDUE;

    // Oldest byte may leave only once four later bytes are behind it
    assign hold_full = hold_cnt == CNT_W'(FCS_BYTES);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_q         <= '1;
            hold_cnt      <= '0;
            out_valid     <= 1'b0;
            error_bad_fcs <= 1'b0;
        end else begin
            out_valid     <= 1'b0;
            error_bad_fcs <= 1'b0;
            if (in_valid) begin
                out_valid <= hold_full;
                if (in_beat.last) begin
                    crc_q    <= '1;
                    hold_cnt <= '0;
                    // A frame already marked bad upstream is not counted here
                    error_bad_fcs <= crc_bad && !in_beat.bad;
                end else begin
                    crc_q <= crc_next;
                    if (!hold_full) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Holdback shift register
    ////////////////////////////////////////////////////////////////////////////

    // On the frame's last beat the held bytes are the last data byte and
    // three FCS bytes, so the oldest one is re-marked as the end of frame
    always_ff @(posedge rx_clk) begin
        if (in_valid) begin
            hold_q        <= {hold_q[HOLD_W-9:0], in_beat.data};
            out_beat.data <= hold_q[HOLD_W-1 -: 8];
            out_beat.last <= in_beat.last;
            out_beat.bad  <= in_beat.last && (in_beat.bad || crc_bad);
        end
    end

endmodule

// File: mac_ctrl_rx_parse.sv
`timescale 1ns/1ps

module mac_ctrl_rx_parse
    import eth_rx_pkg::*;
(
    input  logic      rx_clk,
    input  logic      rx_rst,
    input  logic      in_valid,
    input  rx_beat_t  in_beat,
    input  mcf_cfg_t  cfg,
    output logic      out_valid,
    output rx_beat_t  out_beat,
    output logic      mcf_valid,
    output mcf_info_t mcf_info,
    output logic      stat_rx_mcf
);

    localparam int CNT_W   = $clog2(MCF_HDR_BYTES + 1);
    // EtherType, opcode and quanta, bytes 12 to 17
    localparam int FIELD_W = 16 + $bits(mcf_info_t);

    logic [CNT_W-1:0]   byte_cnt;
    logic [FIELD_W-1:0] hdr_q;
    logic [FIELD_W-1:0] hdr_c;
    logic [15:0]        eth_type;
    mcf_info_t          info_c;
    logic               frame_long;
    logic               is_mcf;
    logic               is_lfc;

    ////////////////////////////////////////////////////////////////////////////
    // Header capture
    ////////////////////////////////////////////////////////////////////////////

    // Shifting stops at the header length, which leaves bytes 12..17 in place
    always_comb begin
        if (byte_cnt < CNT_W'(MCF_HDR_BYTES)) begin
            hdr_c = {hdr_q[FIELD_W-9:0], in_beat.data};
        end else begin
            hdr_c = hdr_q;
        end
    end

    assign eth_type = hdr_c[FIELD_W-1 -: 16];
    assign info_c   = hdr_c[$bits(mcf_info_t)-1:0];

    // Current byte index is byte_cnt, so this byte completes the header
    assign frame_long = byte_cnt >= CNT_W'(MCF_HDR_BYTES - 1);

    assign is_mcf = in_valid && in_beat.last && !in_beat.bad && frame_long
                    && eth_type == cfg.eth_type;
    assign is_lfc = is_mcf && info_c.opcode == cfg.lfc_opcode;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            byte_cnt    <= '0;
            out_valid   <= 1'b0;
            mcf_valid   <= 1'b0;
            stat_rx_mcf <= 1'b0;
        end else begin
            out_valid   <= in_valid;
            mcf_valid   <= is_lfc;
            stat_rx_mcf <= is_mcf;
            if (in_valid) begin
                if (in_beat.last) begin
                    byte_cnt <= '0;
                end else if (byte_cnt < CNT_W'(MCF_HDR_BYTES)) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge rx_clk) begin
        if (in_valid) begin
            hdr_q         <= hdr_c;
            out_beat.data <= in_beat.data;
            out_beat.last <= in_beat.last;
            // Control frames are dropped downstream unless forwarding is on
            out_beat.bad  <= in_beat.bad || (is_mcf && !cfg.forward);
            if (in_beat.last) begin
                mcf_info <= info_c;
            end
        end
    end

endmodule

// File: pause_quanta_timer.sv
`timescale 1ns/1ps

module pause_quanta_timer
    import eth_rx_pkg::*;
#(
    parameter int QUANTA_CYCLES = 64
) (
    input  logic      rx_clk,
    input  logic      rx_rst,
    input  logic      mcf_valid,
    input  mcf_info_t mcf_info,
    input  mcf_cfg_t  cfg,
    input  logic      rx_lfc_en,
    output logic      rx_lfc_req,
    output logic      stat_rx_lfc_pkt,
    output logic      stat_rx_lfc_paused
);

    localparam int                PRESC_W   = $clog2(QUANTA_CYCLES + 1);
    localparam logic [PRESC_W-1:0] PRESC_MAX = PRESC_W'(QUANTA_CYCLES - 1);

    logic [QUANTA_WIDTH-1:0] quanta_cnt;
    logic [PRESC_W-1:0]      presc_cnt;
    logic                    accept;
    logic                    paused;

    assign accept = mcf_valid && cfg.lfc_en && rx_lfc_en;
    assign paused = quanta_cnt != '0;

    // A new frame reloads the count, quanta of zero ends the pause
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt      <= '0;
            presc_cnt       <= '0;
            stat_rx_lfc_pkt <= 1'b0;
        end else begin
            stat_rx_lfc_pkt <= accept;
            if (accept) begin
                quanta_cnt <= mcf_info.quanta;
                presc_cnt  <= PRESC_MAX;
            end else if (paused) begin
                // One quanta is QUANTA_CYCLES byte times
                if (presc_cnt == '0) begin
                    presc_cnt  <= PRESC_MAX;
                    quanta_cnt <= quanta_cnt - 1'b1;
                end else begin
                    presc_cnt <= presc_cnt - 1'b1;
                end
            end
        end
    end

    assign rx_lfc_req         = paused;
    assign stat_rx_lfc_paused = paused;

endmodule

// File: eth_mac_rx.sv
`timescale 1ns/1ps

module eth_mac_rx
    import eth_rx_pkg::*;
#(
    parameter int QUANTA_CYCLES = 64
) (
    input  logic     rx_clk,
    input  logic     rx_rst,
    input  gmii_rx_t gmii,
    input  mcf_cfg_t cfg,
    input  logic     rx_lfc_en,
    output logic     rx_valid,
    output rx_beat_t rx_beat,
    output logic     rx_lfc_req,
    output logic     start_packet,
    output logic     error_bad_frame,
    output logic     error_bad_fcs,
    output logic     stat_rx_mcf,
    output logic     stat_rx_lfc_pkt,
    output logic     stat_rx_lfc_paused
);

    // Framer to FCS check
    logic      framed_valid;
    rx_beat_t  framed_beat;

    // FCS check to control frame parser
    logic      checked_valid;
    rx_beat_t  checked_beat;

    logic      mcf_valid;
    mcf_info_t mcf_info;

    gmii_rx_framer gmii_rx_framer_inst (
        .rx_clk          (rx_clk),
        .rx_rst          (rx_rst),
        .gmii            (gmii),
        .out_valid       (framed_valid),
        .out_beat        (framed_beat),
        .start_packet    (start_packet),
        .error_bad_frame (error_bad_frame)
    );

    eth_fcs_check eth_fcs_check_inst (
        .rx_clk        (rx_clk),
        .rx_rst        (rx_rst),
        .in_valid      (framed_valid),
        .in_beat       (framed_beat),
        .out_valid     (checked_valid),
        .out_beat      (checked_beat),
        .error_bad_fcs (error_bad_fcs)
    );

    mac_ctrl_rx_parse mac_ctrl_rx_parse_inst (
        .rx_clk      (rx_clk),
        .rx_rst      (rx_rst),
        .in_valid    (checked_valid),
        .in_beat     (checked_beat),
        .cfg         (cfg),
        .out_valid   (rx_valid),
        .out_beat    (rx_beat),
        .mcf_valid   (mcf_valid),
        .mcf_info    (mcf_info),
        .stat_rx_mcf (stat_rx_mcf)
    );

    pause_quanta_timer #(
        .QUANTA_CYCLES (QUANTA_CYCLES)
    ) pause_quanta_timer_inst (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .mcf_valid          (mcf_valid),
        .mcf_info           (mcf_info),
        .cfg                (cfg),
        .rx_lfc_en          (rx_lfc_en),
        .rx_lfc_req         (rx_lfc_req),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

endmodule

// File: eth_mac_rx_checker.sv
`timescale 1ns/1ps

module eth_mac_rx_checker
    import eth_rx_pkg::*;
(
    input  logic     rx_clk,
    input  logic     rx_rst,
    input  logic     rx_valid,
    input  rx_beat_t rx_beat,
    input  logic     rx_lfc_req,
    input  logic     start_packet,
    input  logic     error_bad_frame,
    input  logic     error_bad_fcs,
    input  logic     stat_rx_mcf,
    input  logic     stat_rx_lfc_pkt,
    input  logic     stat_rx_lfc_paused
);

    logic [7:0] exp_q[$];
    logic       exp_bad;
    logic       req_prev;
    logic       req_at_start;
    logic       frame_done;
    logic       run_done;
    int         test_id;
    int         test_errors;
    int         sp_cnt;
    int         bframe_cnt;
    int         bfcs_cnt;
    int         mcf_cnt;
    int         lfc_cnt;
    int         rise_cnt;
    int         paused_cnt;
    int         run_len;
    int         last_run;
    int         tests_done;
    int         failed_tests;
    int         total_errors;

    initial begin
        exp_bad      = 1'b0;
        req_prev     = 1'b0;
        req_at_start = 1'b0;
        frame_done   = 1'b0;
        run_done     = 1'b0;
        test_id      = 0;
        test_errors  = 0;
        run_len      = 0;
        last_run     = 0;
        tests_done   = 0;
        failed_tests = 0;
        total_errors = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        test_errors = test_errors + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Test %0d: %s", test_id, what);
        test_errors = test_errors + 1;
    endtask

    task automatic expect_byte(input logic [7:0] b);
        exp_q.push_back(b);
    endtask

    task automatic begin_test(input int id, input logic bad);
        test_id      = id;
        exp_bad      = bad;
        test_errors  = 0;
        sp_cnt       = 0;
        bframe_cnt   = 0;
        bfcs_cnt     = 0;
        mcf_cnt      = 0;
        lfc_cnt      = 0;
        rise_cnt     = 0;
        paused_cnt   = 0;
        frame_done   = 1'b0;
        run_done     = 1'b0;
        req_at_start = rx_lfc_req;
        exp_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor, sampled on the falling edge where outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            if (start_packet)    sp_cnt     = sp_cnt + 1;
            if (error_bad_frame) bframe_cnt = bframe_cnt + 1;
            if (error_bad_fcs)   bfcs_cnt   = bfcs_cnt + 1;
            if (stat_rx_mcf)     mcf_cnt    = mcf_cnt + 1;
            if (stat_rx_lfc_pkt) lfc_cnt    = lfc_cnt + 1;

            if (rx_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("received a byte when none was expected");
                end else begin
                    if (rx_beat.data != exp_q[0])
                        report_mismatch("rx_beat.data", 32'(rx_beat.data), 32'(exp_q[0]));
                    if (rx_beat.last != (exp_q.size() == 1))
                        report_mismatch("rx_beat.last", 32'(rx_beat.last),
                                        32'(exp_q.size() == 1));
                    // Only the final byte of a frame may carry bad
                    if (rx_beat.bad != (exp_bad && exp_q.size() == 1))
                        report_mismatch("rx_beat.bad", 32'(rx_beat.bad),
                                        32'(exp_bad && exp_q.size() == 1));
                    void'(exp_q.pop_front());
                end
                if (rx_beat.last) begin
                    if (exp_q.size() != 0)
                        report_failure("frame ended before all payload bytes arrived");
                    exp_q.delete();
                    frame_done = 1'b1;
                end
            end

            if (stat_rx_lfc_paused) paused_cnt = paused_cnt + 1;

            // Pause request run length, counted from the rise
            if (rx_lfc_req) begin
                if (!req_prev) begin
                    rise_cnt = rise_cnt + 1;
                    run_len  = 0;
                end
                run_len = run_len + 1;
            end else if (req_prev) begin
                last_run = run_len;
                run_done = 1'b1;
            end
            req_prev = rx_lfc_req;
        end
    end

    // Pause modes: 0 none, 1 full run, 2 run starts, 3 run ends
    task automatic finish_test(input int e_sp, input int e_bframe, input int e_bfcs,
                               input int e_mcf, input int e_lfc, input int e_pmode,
                               input int e_run);
        if (!frame_done) report_failure("no last beat seen for the frame");
        if (sp_cnt != e_sp)         report_mismatch("start_packet", sp_cnt, e_sp);
        if (bframe_cnt != e_bframe) report_mismatch("error_bad_frame", bframe_cnt, e_bframe);
        if (bfcs_cnt != e_bfcs)     report_mismatch("error_bad_fcs", bfcs_cnt, e_bfcs);
        if (mcf_cnt != e_mcf)       report_mismatch("stat_rx_mcf", mcf_cnt, e_mcf);
        if (lfc_cnt != e_lfc)       report_mismatch("stat_rx_lfc_pkt", lfc_cnt, e_lfc);
        case (e_pmode)
            1: begin
                if (rise_cnt != 1) report_mismatch("rx_lfc_req rises", rise_cnt, 1);
                if (last_run != e_run) report_mismatch("rx_lfc_req cycles", last_run, e_run);
                if (paused_cnt != e_run)
                    report_mismatch("stat_rx_lfc_paused cycles", paused_cnt, e_run);
            end
            2: begin
                if (rise_cnt != 1) report_mismatch("rx_lfc_req rises", rise_cnt, 1);
                if (!rx_lfc_req) report_failure("pause request is not active after the frame");
                if (!stat_rx_lfc_paused)
                    report_failure("paused status is not active after the frame");
            end
            3: begin
                if (!req_at_start) report_failure("pause request was not active beforehand");
                if (rx_lfc_req) report_failure("pause request stayed active after zero quanta");
                if (stat_rx_lfc_paused)
                    report_failure("paused status stayed active after zero quanta");
            end
            default: begin
                if (rise_cnt != 0) report_mismatch("rx_lfc_req rises", rise_cnt, 0);
                if (rx_lfc_req) report_failure("pause request is active unexpectedly");
                if (paused_cnt != 0)
                    report_mismatch("stat_rx_lfc_paused cycles", paused_cnt, 0);
            end
        endcase
        tests_done   = tests_done + 1;
        total_errors = total_errors + test_errors;
        if (test_errors == 0) begin
            $display("Test %0d ok", test_id);
        end else begin
            failed_tests = failed_tests + 1;
            $display("Test %0d failed with %0d errors", test_id, test_errors);
        end
    endtask

endmodule

// File: tb_eth_mac_rx.sv
`timescale 1ns/1ps

module tb_eth_mac_rx
    import eth_rx_pkg::*;
();

    localparam int QC        = 4;
    localparam int MAX_TESTS = 16;
    localparam int MAX_BYTES = 128;

    logic     rx_clk;
    logic     rx_rst;
    gmii_rx_t gmii;
    mcf_cfg_t cfg;
    logic     rx_lfc_en;
    logic     rx_valid;
    rx_beat_t rx_beat;
    logic     rx_lfc_req;
    logic     start_packet;
    logic     error_bad_frame;
    logic     error_bad_fcs;
    logic     stat_rx_mcf;
    logic     stat_rx_lfc_pkt;
    logic     stat_rx_lfc_paused;

    // One row per test, as read from the data file
    logic [15:0] t_etype[MAX_TESTS];
    logic [15:0] t_opcode[MAX_TESTS];
    logic [15:0] t_quanta[MAX_TESTS];
    logic [15:0] t_f[MAX_TESTS][13];
    int          num_tests;
    int          cycle_limit;
    int          cycle_cnt;

    eth_mac_rx #(
        .QUANTA_CYCLES (QC)
    ) eth_mac_rx_inst (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .gmii               (gmii),
        .cfg                (cfg),
        .rx_lfc_en          (rx_lfc_en),
        .rx_valid           (rx_valid),
        .rx_beat            (rx_beat),
        .rx_lfc_req         (rx_lfc_req),
        .start_packet       (start_packet),
        .error_bad_frame    (error_bad_frame),
        .error_bad_fcs      (error_bad_fcs),
        .stat_rx_mcf        (stat_rx_mcf),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

    eth_mac_rx_checker checker_inst (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .rx_valid           (rx_valid),
        .rx_beat            (rx_beat),
        .rx_lfc_req         (rx_lfc_req),
        .start_packet       (start_packet),
        .error_bad_frame    (error_bad_frame),
        .error_bad_fcs      (error_bad_fcs),
        .stat_rx_mcf        (stat_rx_mcf),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

    initial begin
        rx_clk = 1'b0;
        forever #10 rx_clk = ~rx_clk;
    end

    always @(posedge rx_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame construction
    ////////////////////////////////////////////////////////////////////////////

    // IEEE 802.3 CRC-32, reflected, one bit at a time
    function automatic logic [31:0] fcs_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int k = 0; k < 8; k++) begin
            fb = r[0] ^ b[k];
            r  = {1'b0, r[31:1]};
            if (fb) r = r ^ 32'hEDB88320;
        end
        return r;
    endfunction

    function automatic logic [7:0] body_byte(input int t, input int i);
        logic [47:0] dst;
        dst = 48'h0180C2000001;
        if (i < 6) return dst[47-8*i -: 8];
        if (i < 12) return 8'(8'h10 + i);
        case (i)
            12: return t_etype[t][15:8];
            13: return t_etype[t][7:0];
            14: return t_opcode[t][15:8];
            15: return t_opcode[t][7:0];
            16: return t_quanta[t][15:8];
            17: return t_quanta[t][7:0];
            default: return 8'(i * 7 + 3);
        endcase
    endfunction

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        logic [15:0] f[16];
        fd = $fopen("eth_mac_rx_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open eth_mac_rx_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
                if (line.len() > 2 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (n == 16) begin
                        t_etype[num_tests]  = f[0];
                        t_opcode[num_tests] = f[1];
                        t_quanta[num_tests] = f[2];
                        for (int k = 0; k < 13; k++) t_f[num_tests][k] = f[k+3];
                        num_tests = num_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Fields of t_f: 0 len, 1 er_pos, 2 fcs_xor, 3 fwd, 4 lfc_en, 5 rx_lfc_en,
    // 6 bad, 7 start, 8 bad_frame, 9 bad_fcs, 10 mcf, 11 lfc_pkt, 12 pause mode
    task automatic send_frame(input int t);
        logic [7:0]  bytes[MAX_BYTES];
        logic [7:0]  b;
        logic [31:0] crc;
        int          n;
        n   = 0;
        crc = '1;
        for (int k = 0; k < 7; k++) begin
            bytes[n] = 8'h55;
            n = n + 1;
        end
        bytes[n] = 8'hD5;
        n = n + 1;
        for (int i = 0; i < int'(t_f[t][0]); i++) begin
            b        = body_byte(t, i);
            bytes[n] = b;
            crc      = fcs_update(crc, b);
            n        = n + 1;
            checker_inst.expect_byte(b);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            bytes[n] = crc[8*k +: 8] ^ ((k == 0) ? t_f[t][2][7:0] : 8'h00);
            n = n + 1;
        end
        for (int j = 0; j < n; j++) begin
            @(posedge rx_clk);
            #1;
            gmii.rxd   = bytes[j];
            gmii.rx_dv = 1'b1;
            gmii.rx_er = (j >= 8) && ((j - 7) == int'(t_f[t][1]));
        end
        @(posedge rx_clk);
        #1;
        gmii = '0;
    endtask

    task automatic run_test(input int t);
        int gap;
        cfg.forward = t_f[t][3][0];
        cfg.lfc_en  = t_f[t][4][0];
        rx_lfc_en   = t_f[t][5][0];
        checker_inst.begin_test(t + 1, t_f[t][6][0]);
        send_frame(t);
        while (!checker_inst.frame_done) @(posedge rx_clk);
        repeat (3) @(posedge rx_clk);
        if (t_f[t][12] == 16'd1) begin
            while (!checker_inst.run_done) @(posedge rx_clk);
        end
        checker_inst.finish_test(t_f[t][7], t_f[t][8], t_f[t][9], t_f[t][10], t_f[t][11],
                                 t_f[t][12], int'(t_quanta[t]) * QC);
        gap = 12 + int'($urandom % 16);
        repeat (gap) @(posedge rx_clk);
        #1;
    endtask

    initial begin
        rx_rst         = 1'b1;
        gmii           = '0;
        cfg            = '0;
        cfg.eth_type   = 16'h8808;
        cfg.lfc_opcode = 16'h0001;
        rx_lfc_en      = 1'b0;
        num_tests      = 0;
        cycle_limit    = 0;
        cycle_cnt      = 0;
        void'($urandom(32'hc0da_27c6));
        load_tests();
        // Frame, gap and drain time per test, plus any pause that runs inside it
        cycle_limit = 500;
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit = cycle_limit + int'(t_f[t][0]) + 70;
            if (t_f[t][12] == 16'd1 || t_f[t][12] == 16'd2)
                cycle_limit = cycle_limit + int'(t_quanta[t]) * QC;
        end
        repeat (4) @(posedge rx_clk);
        #1;
        rx_rst = 1'b0;
        for (int t = 0; t < num_tests; t++) run_test(t);
        repeat (5) @(posedge rx_clk);
        $display("Tests run %0d, failed %0d, errors %0d", checker_inst.tests_done,
                 checker_inst.failed_tests, checker_inst.total_errors);
        if (num_tests > 0 && checker_inst.failed_tests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: eth_mac_rx_tests.txt
# etype opcode quanta len er_pos fcs_xor fwd lfc_en rx_lfc_en, all hex, then expected:
# bad start bad_frame bad_fcs mcf lfc_pkt pause_mode (0 none 1 full 2 starts 3 ends)
0800 0000 0000 40 0 00 0 1 1 0 1 0 0 0 0 0
0800 0000 0000 40 0 5a 0 1 1 1 1 0 1 0 0 0
8808 0001 0010 3c 14 00 0 1 1 1 1 1 0 0 0 0
8808 0001 0003 3c 0 00 0 1 1 1 1 0 0 1 1 1
8808 0001 0040 3c 0 00 0 1 1 1 1 0 0 1 1 2
8808 0001 0000 3c 0 00 0 1 1 1 1 0 0 1 1 3
8808 0001 0005 3c 0 00 0 1 0 1 1 0 0 1 0 0
8808 0001 0005 3c 0 00 0 0 1 1 1 0 0 1 0 0
8808 0001 0002 3c 0 00 1 1 1 0 1 0 0 1 1 1
0806 0001 0002 3c 0 00 1 1 1 0 1 0 0 0 0 0
8808 0002 0004 3c 0 00 0 1 1 1 1 0 0 1 0 0

// File: sim.f
eth_rx_pkg.sv
gmii_rx_framer.sv
eth_fcs_check.sv
mac_ctrl_rx_parse.sv
pause_quanta_timer.sv
eth_mac_rx.sv
eth_mac_rx_checker.sv
tb_eth_mac_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module tb_eth_mac_rx -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "Build or run of the simulation failed"; exit 1; }
grep -qx "Testbench passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
